//--- int_exec.f
source/int_op_pkg.sv
source/backend_pkg.sv
source/alu_unit.sv
source/branch_unit.sv
source/exec_wb_stage.sv
source/int_exec_top.sv
tb/tb_int_exec.sv

//--- run_sim.sh
#!/bin/sh
# build and run the integer execute unit testbench with verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_int_exec -f int_exec.f -o tb_int_exec_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_int_exec_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Simulation finished: FAIL" "$log_file"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

//--- source/alu_unit.sv
module alu_unit
    import int_op_pkg::*;
    import backend_pkg::*;
(
    input  issue_bundle_t issue,
    output xlen_t         result
);
    xlen_t              s_imm;
    xlen_t              lui_imm;
    xlen_t              data1;
    xlen_t              data2;
    xlen_t              add_src2;
    xlen_t              add_result;
    logic               add_cin;
    logic               add_cout;
    logic               slt_s;
    logic               slt_u;
    logic               slt_bit;
    logic               padding;
    shamt_t             shamt;
    logic signed [xlen:0] sr_src;
    xlen_t              sl_data;
    xlen_t              sr_data;
    xlen_t              auipc_addr;

    assign s_imm   = {{(xlen-12){issue.imm[imm_w-1]}}, issue.imm[imm_w-1 -: 12]};
    assign lui_imm = {issue.imm, 12'b0};

    assign data1 = issue.rs1_data;
    assign data2 = issue.immv ? s_imm : issue.rs2_data;

    // sub and slt share the adder through the inverted operand
    always_comb begin
        case (issue.alu_op)
            alu_sub, alu_slt: begin
                add_src2 = ~data2;
                add_cin  = 1'b1;
            end
            default: begin
                add_src2 = data2;
                add_cin  = 1'b0;
            end
        endcase
    end

    assign {add_cout, add_result} = {1'b0, data1} + {1'b0, add_src2} + {{xlen{1'b0}}, add_cin};

    // negative vs positive, or same sign and negative difference
    assign slt_s = (data1[xlen-1] & ~data2[xlen-1])
                 | ((data1[xlen-1] ~^ data2[xlen-1]) & add_result[xlen-1]);
    assign slt_u   = ~add_cout;   // borrow out
    assign slt_bit = issue.uext ? slt_u : slt_s;

    assign padding = issue.rs1_data[xlen-1] & ~issue.uext;
    assign shamt   = data2[shamt_w-1:0];
    assign sr_src  = {padding, data1};
    assign sl_data = data1 << shamt;
    assign sr_data = xlen_t'(sr_src >>> shamt);

    assign auipc_addr = issue.pc + lui_imm;

    always_comb begin
        case (issue.alu_op)
            alu_add:   result = add_result;
            alu_sub:   result = add_result;
            alu_slt:   result = {{(xlen-1){1'b0}}, slt_bit};
            alu_and:   result = data1 & data2;
            alu_or:    result = data1 | data2;
            alu_xor:   result = data1 ^ data2;
            alu_sl:    result = sl_data;
            alu_sr:    result = sr_data;
            alu_lui:   result = lui_imm;
            alu_auipc: result = auipc_addr;
            default:   result = '0;
        endcase
    end

endmodule

//--- source/backend_pkg.sv
package backend_pkg;

    import int_op_pkg::*;

    localparam int xlen    = 32;
    localparam int rob_w   = 6;
    localparam int areg_w  = 5;
    localparam int shamt_w = $clog2(xlen);

    typedef logic [xlen-1:0]    xlen_t;
    typedef br_target_t         vaddr_t;   // same width as the branch target
    typedef logic [rob_w-1:0]   rob_idx_t;
    typedef logic [areg_w-1:0]  areg_t;
    typedef logic [shamt_w-1:0] shamt_t;

    typedef struct packed {
        logic       intv;       // 1 for alu, 0 for branch
        alu_op_e    alu_op;
        branch_op_e br_op;
        logic       uext;
        logic       immv;
        logic       rvc;
        imm_t       imm;
        xlen_t      rs1_data;
        xlen_t      rs2_data;
        vaddr_t     pc;
        logic       pred_taken;
        vaddr_t     pred_target;
        logic       we;
        rob_idx_t   rob_idx;
        areg_t      rd;
    } issue_bundle_t;

    typedef struct packed {
        logic     en;
        logic     we;
        rob_idx_t rob_idx;
        areg_t    rd;
        xlen_t    res;
    } wb_data_t;

endpackage

//--- source/branch_unit.sv
module branch_unit
    import int_op_pkg::*;
    import backend_pkg::*;
(
    input  issue_bundle_t issue,
    output branch_res_t   br_res,
    output xlen_t         link_result
);
    logic   equal;
    logic   lt_u;
    logic   lt_s;
    logic   lt;
    logic   dir;
    xlen_t  br_offset;
    xlen_t  jalr_imm;
    xlen_t  jalr_sum;
    vaddr_t br_target;
    vaddr_t jalr_target;
    vaddr_t link_addr;
    logic   branch_error;
    logic   indirect_error;

    assign equal = issue.rs1_data == issue.rs2_data;
    assign lt_u  = issue.rs1_data < issue.rs2_data;
    // differing signs decide on their own
    assign lt_s  = (issue.rs1_data[xlen-1] ^ issue.rs2_data[xlen-1]) ?
                   issue.rs1_data[xlen-1] : lt_u;
    assign lt    = issue.uext ? lt_u : lt_s;

    always_comb begin
        case (issue.br_op)
            br_beq:  dir = equal;
            br_bne:  dir = ~equal;
            br_blt:  dir = lt;
            br_bge:  dir = ~lt;
            br_jal:  dir = 1'b1;
            br_jalr: dir = 1'b1;
            default: dir = 1'b0;
        endcase
    end

    assign br_offset = {{(xlen-13){issue.imm[12]}}, issue.imm[12:1], 1'b0};
    assign jalr_imm  = {{(xlen-12){issue.imm[imm_w-1]}}, issue.imm[imm_w-1 -: 12]};
    assign jalr_sum  = issue.rs1_data + jalr_imm;

    assign br_target   = issue.pc + br_offset;
    assign jalr_target = {jalr_sum[xlen-1:1], 1'b0};
    assign link_addr   = issue.pc + (issue.rvc ? 32'd2 : 32'd4);

    assign branch_error   = (dir ^ issue.pred_taken)
                          | (dir & issue.pred_taken & (issue.pred_target != br_target));
    assign indirect_error = ~issue.pred_taken | (issue.pred_target != jalr_target);

    always_comb begin
        br_res.direction = dir;
        br_res.rvc       = issue.rvc;
        if (issue.br_op == br_jalr) begin
            br_res.target = jalr_target;
        end else if (dir) begin
            br_res.target = br_target;
        end else begin
            br_res.target = link_addr;   // fall through
        end
        case (issue.br_op)
            br_jalr: br_res.error = indirect_error;
            br_jal:  br_res.error = 1'b0;   // target known at decode
            default: br_res.error = branch_error;
        endcase
    end

    assign link_result = link_addr;

endmodule

//--- source/exec_wb_stage.sv
module exec_wb_stage
    import int_op_pkg::*;
    import backend_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          issue_valid,
    input  issue_bundle_t issue,
    input  xlen_t         alu_result,
    input  xlen_t         link_result,
    input  branch_res_t   br_res_comb,
    output wb_data_t      wb,
    output logic          br_valid,
    output branch_res_t   br_res
);
    xlen_t       res_sel;
    logic        wb_en_q;
    logic        br_valid_q;
    logic        we_q;
    rob_idx_t    rob_idx_q;
    areg_t       rd_q;
    xlen_t       res_q;
    branch_res_t br_res_q;

    assign res_sel = issue.intv ? alu_result : link_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en_q    <= 1'b0;
            br_valid_q <= 1'b0;
        end else begin
            wb_en_q    <= issue_valid;
            br_valid_q <= issue_valid & ~issue.intv;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            we_q      <= issue.we;
            rob_idx_q <= issue.rob_idx;
            rd_q      <= issue.rd;
            res_q     <= res_sel;
        end
        if (issue_valid & ~issue.intv) begin
            br_res_q <= br_res_comb;
        end
    end

    assign wb = '{en: wb_en_q, we: we_q, rob_idx: rob_idx_q, rd: rd_q, res: res_q};
    assign br_valid = br_valid_q;
    assign br_res   = br_res_q;

endmodule

//--- source/int_exec_top.sv
module int_exec_top
    import int_op_pkg::*;
    import backend_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          issue_valid,
    input  issue_bundle_t issue,
    output wb_data_t      wb,
    output logic          br_valid,
    output branch_res_t   br_res
);
    xlen_t       alu_result;
    xlen_t       link_result;
    branch_res_t br_res_comb;

    alu_unit u_alu (
        .issue  (issue),
        .result (alu_result)
    );

    branch_unit u_branch (
        .issue       (issue),
        .br_res      (br_res_comb),
        .link_result (link_result)
    );

    // single register stage for both paths
    exec_wb_stage u_wb_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .alu_result  (alu_result),
        .link_result (link_result),
        .br_res_comb (br_res_comb),
        .wb          (wb),
        .br_valid    (br_valid),
        .br_res      (br_res)
    );

endmodule

//--- source/int_op_pkg.sv
package int_op_pkg;

    localparam int alu_op_w = 4;
    localparam int br_op_w  = 3;
    localparam int imm_w    = 20;   // decoded immediate field
    localparam int vaddr_w  = 32;

    typedef enum logic [alu_op_w-1:0] {
        alu_add   = 4'h0,
        alu_sub   = 4'h1,
        alu_slt   = 4'h2,   // uext selects unsigned
        alu_and   = 4'h3,
        alu_or    = 4'h4,
        alu_xor   = 4'h5,
        alu_sl    = 4'h6,
        alu_sr    = 4'h7,   // uext selects logical
        alu_lui   = 4'h8,
        alu_auipc = 4'h9
    } alu_op_e;

    typedef enum logic [br_op_w-1:0] {
        br_beq  = 3'h0,
        br_bne  = 3'h1,
        br_blt  = 3'h2,
        br_bge  = 3'h3,
        br_jal  = 3'h4,
        br_jalr = 3'h5
    } branch_op_e;

    // I-type in [19:8], branch offset in [12:1], upper immediate uses all bits
    typedef logic [imm_w-1:0] imm_t;

    typedef logic [vaddr_w-1:0] br_target_t;

    typedef struct packed {
        logic       direction;
        logic       error;      // redirect needed
        br_target_t target;
        logic       rvc;
    } branch_res_t;

endpackage

//--- tb/int_exec_stimulus.txt
// ctrl digits: valid intv alu_op br_op uext immv rvc pred_taken | wb: we 0 rob 00 rd
// imm rs1 rs2 pc pred_target | expected res target | flags: dir err | ffffffff ends
11000000 10010001 00000000 00000010 00000020 00000000 00000000 00000030 00000000 00000000
11000100 10020002 000FFF00 00000010 12345678 00000000 00000000 0000000F 00000000 00000000
11100000 10030003 00000000 00000005 00000007 00000000 00000000 FFFFFFFE 00000000 00000000
11300000 10040004 00000000 F0F0F0F0 FF00FF00 00000000 00000000 F000F000 00000000 00000000
11400000 10050005 00000000 F0F0F0F0 FF00FF00 00000000 00000000 FFF0FFF0 00000000 00000000
11500100 10060006 0000FF00 0000FF0F 00000000 00000000 00000000 0000FFF0 00000000 00000000
11800000 10070007 000ABCDE 00000000 00000000 00000000 00000000 ABCDE000 00000000 00000000
11900000 10080008 00000001 00000000 00000000 80000000 00000000 80001000 00000000 00000000
11200000 10090009 00000000 FFFFFFFF 00000001 00000000 00000000 00000001 00000000 00000000
11201000 100A000A 00000000 FFFFFFFF 00000001 00000000 00000000 00000000 00000000 00000000
11201000 100B000B 00000000 00000003 80000000 00000000 00000000 00000001 00000000 00000000
11600000 100C000C 00000000 00000001 0000001F 00000000 00000000 80000000 00000000 00000000
11600100 100D000D 00000000 12345678 FFFFFFFF 00000000 00000000 12345678 00000000 00000000
11700000 100E000E 00000000 80000000 0000001F 00000000 00000000 FFFFFFFF 00000000 00000000
11701000 100F000F 00000000 80000000 0000001F 00000000 00000000 00000001 00000000 00000000
11700000 10100010 00000000 F0000000 00000024 00000000 00000000 FF000000 00000000 00000000
11700000 10110011 00000000 80000001 00000000 00000000 00000000 80000001 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
10000001 00120000 00000010 00000055 00000055 00001000 00001010 00001004 00001010 00000010
10010000 00130000 00000010 00000055 00000055 00001000 00000000 00001004 00001004 00000000
10020000 00140000 00001FF8 FFFFFFF0 00000001 00001000 00000000 00001004 00000FF8 00000011
10021011 00150000 00001FF8 FFFFFFF0 00000001 00001000 00000FF8 00001002 00001002 00000001
10030001 00160000 00000100 00000007 00000007 00001000 00002000 00001004 00001100 00000011
10031000 00170000 00000100 00000001 80000000 00001000 00000000 00001004 00001004 00000000
10040000 10200001 00000800 00000000 00000000 00002000 00000000 00002004 00002800 00000010
10040011 10210005 00001FFC 00000000 00000000 00002000 00001234 00002002 00001FFC 00000010
10050001 1022001F 00001000 00003001 00000000 00002100 00003010 00002104 00003010 00000010
10050000 1023001F 00001000 00003001 00000000 00002100 00003010 00002104 00003010 00000011
10050011 1024001E 000FFD00 00004000 00000000 00002100 00003FFD 00002102 00003FFC 00000011
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
11000100 003F001F 00000100 7FFFFFFF 00000000 00000000 00000000 80000000 00000000 00000000
FFFFFFFF 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

//--- tb/tb_int_exec.sv
module tb_int_exec
    import int_op_pkg::*;
    import backend_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          rec_words   = 10;   // 32-bit words per record
    localparam int          max_records = 64;
    localparam logic [31:0] end_marker  = 32'hffff_ffff;

    logic          clk;
    logic          rst_n;
    logic          issue_valid;
    issue_bundle_t issue;
    wb_data_t      wb;
    logic          br_valid;
    branch_res_t   br_res;

    logic [31:0] stim_mem [0:max_records*rec_words-1];
    int          n_records;
    int          cycle_limit = max_records + 20;
    int          cycle_count = 0;

    int_exec_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .wb          (wb),
        .br_valid    (br_valid),
        .br_res      (br_res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: test did not complete within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic compare_value(input string what, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0d ns %s: got %h, expected %h", $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic apply_record(input int idx);
        int          base;
        logic [31:0] ctrl;
        logic [31:0] wbw;
        base = idx * rec_words;
        ctrl = stim_mem[base];
        wbw  = stim_mem[base + 1];
        issue_valid       = ctrl[28];
        issue.intv        = ctrl[24];
        issue.alu_op      = alu_op_e'(ctrl[23:20]);
        issue.br_op       = branch_op_e'(ctrl[18:16]);
        issue.uext        = ctrl[12];
        issue.immv        = ctrl[8];
        issue.rvc         = ctrl[4];
        issue.pred_taken  = ctrl[0];
        issue.imm         = stim_mem[base + 2][imm_w-1:0];
        issue.rs1_data    = stim_mem[base + 3];
        issue.rs2_data    = stim_mem[base + 4];
        issue.pc          = stim_mem[base + 5];
        issue.pred_target = stim_mem[base + 6];
        issue.we          = wbw[28];
        issue.rob_idx     = wbw[21:16];
        issue.rd          = wbw[4:0];
    endtask

    task automatic verify_outputs(input int idx);
        int          base;
        logic [31:0] ctrl;
        logic [31:0] wbw;
        logic [31:0] flags;
        logic        valid;
        logic        intv;
        base  = idx * rec_words;
        ctrl  = stim_mem[base];
        wbw   = stim_mem[base + 1];
        flags = stim_mem[base + 9];
        valid = ctrl[28];
        intv  = ctrl[24];
        compare_value("wb.en", 32'(wb.en), 32'(valid));
        compare_value("br_valid", 32'(br_valid), 32'(valid & ~intv));
        if (valid) begin
            compare_value("wb.we", 32'(wb.we), 32'(wbw[28]));
            compare_value("wb.rob_idx", 32'(wb.rob_idx), 32'(wbw[21:16]));
            compare_value("wb.rd", 32'(wb.rd), 32'(wbw[4:0]));
            compare_value("wb.res", wb.res, stim_mem[base + 7]);
            if (!intv) begin
                compare_value("br_res.direction", 32'(br_res.direction), 32'(flags[4]));
                compare_value("br_res.error", 32'(br_res.error), 32'(flags[0]));
                compare_value("br_res.target", br_res.target, stim_mem[base + 8]);
                compare_value("br_res.rvc", 32'(br_res.rvc), 32'(ctrl[4]));
            end
        end
    endtask

    initial begin
        issue       = '0;
        issue_valid = 1'b1;   // branch strobe held high while in reset
        rst_n       = 1'b0;
        $readmemh("tb/int_exec_stimulus.txt", stim_mem);
        n_records = 0;
        while (n_records < max_records && stim_mem[n_records*rec_words] !== end_marker) begin
            n_records++;
        end
        if (n_records == 0 || n_records == max_records) begin
            $display("stimulus file is empty or has no end marker");
            $display("Simulation finished: FAIL");
            $fatal(1, "bad stimulus file");
        end
        cycle_limit = n_records + 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_value("wb.en in reset", 32'(wb.en), 32'd0);
        compare_value("br_valid in reset", 32'(br_valid), 32'd0);
        issue_valid = 1'b0;
        rst_n       = 1'b1;
        @(negedge clk);
        compare_value("wb.en after reset", 32'(wb.en), 32'd0);
        compare_value("br_valid after reset", 32'(br_valid), 32'd0);
        for (int i = 0; i < n_records; i++) begin
            apply_record(i);
            @(negedge clk);
            verify_outputs(i);   // result of the issue one edge earlier
        end
        issue_valid = 1'b0;
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
